//--- source/i2cPkg.sv
`default_nettype none

package i2cPkg;

    localparam int byteWidth = 8;
    localparam int phasesPerBit = 4;
    localparam int phaseBits = $clog2(phasesPerBit);
    // scl is high in the two middle phases, line sampled in the second one
    localparam logic [phaseBits-1:0] samplePhase = phaseBits'(2);
    localparam logic [phaseBits-1:0] lastPhase = phaseBits'(phasesPerBit - 1);

    // Host register map
    localparam int regAddrWidth = 3;
    localparam logic [regAddrWidth-1:0] regCtrl = 3'd0;
    localparam logic [regAddrWidth-1:0] regDevAddr = 3'd1;
    localparam logic [regAddrWidth-1:0] regPtr = 3'd2;
    localparam logic [regAddrWidth-1:0] regWrData = 3'd3;
    localparam logic [regAddrWidth-1:0] regStatus = 3'd4;
    localparam logic [regAddrWidth-1:0] regRdData = 3'd5;

    // Bit positions inside regCtrl and regStatus
    localparam int ctrlEnBit = 0;
    localparam int ctrlModeLsb = 1;
    localparam int statusBusyBit = 0;
    localparam int statusAckErrBit = 1;

    typedef enum logic [1:0] {
        modeIdle  = 2'd0,
        modeWrite = 2'd1,
        modeRead  = 2'd2
    } i2cMode_e;

    typedef enum logic [2:0] {
        opStart     = 3'd0,
        opRestart   = 3'd1,
        opStop      = 3'd2,
        opWriteByte = 3'd3,
        opReadByte  = 3'd4
    } busOp_e;

    typedef struct packed {
        busOp_e op;
        logic [byteWidth-1:0] data;
        logic ackOut;
    } busCmd_s;

    typedef struct packed {
        logic [6:0] devAddr;
        logic [byteWidth-1:0] regPtr;
        logic [byteWidth-1:0] wrData;
        logic launchRead;
    } i2cConfig_s;

    typedef struct packed {
        logic busy;
        logic ackError;
        logic [byteWidth-1:0] rdData;
    } i2cResult_s;

    // Shifted out as raw, built up field by field
    typedef union packed {
        logic [byteWidth-1:0] raw;
        struct packed {
            logic [6:0] devAddr;
            logic rnw;
        } fields;
    } addrByte_u;

endpackage

`default_nettype wire

//--- source/i2cRegBlock.sv
`timescale 1ns/10ps
`default_nettype none

module i2cRegBlock (
    input  wire logic FSM_Clk,
    input  wire logic reset,
    input  wire logic regWrEn,
    input  wire logic [i2cPkg::regAddrWidth-1:0] regAddr,
    input  wire logic [i2cPkg::byteWidth-1:0] regWrData,
    input  wire i2cPkg::i2cResult_s result,
    output logic [i2cPkg::byteWidth-1:0] regRdData,
    output i2cPkg::i2cConfig_s cfg,
    output logic launch
);

    logic ctrlEn;
    i2cPkg::i2cMode_e ctrlMode;
    i2cPkg::i2cMode_e lastMode;
    i2cPkg::i2cMode_e wrMode;
    logic [i2cPkg::byteWidth-1:0] devAddrReg;
    logic [i2cPkg::byteWidth-1:0] ptrReg;
    logic [i2cPkg::byteWidth-1:0] wrDataReg;
    logic [i2cPkg::byteWidth-1:0] rdDataReg;
    logic ackError;
    logic busyPrev;
    logic ctrlWrite;

    assign ctrlWrite = regWrEn && (regAddr == i2cPkg::regCtrl);
    assign wrMode = i2cPkg::i2cMode_e'(regWrData[i2cPkg::ctrlModeLsb +: 2]);

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            ctrlEn <= 1'b0;
            ctrlMode <= i2cPkg::modeIdle;
            lastMode <= i2cPkg::modeIdle;
            devAddrReg <= '0;
            ptrReg <= '0;
            wrDataReg <= '0;
            rdDataReg <= '0;
            ackError <= 1'b0;
            busyPrev <= 1'b0;
            launch <= 1'b0;
        end else begin
            launch <= 1'b0;
            busyPrev <= result.busy;
            if (ctrlWrite) begin
                ctrlEn <= regWrData[i2cPkg::ctrlEnBit];
                ctrlMode <= wrMode;
                // Idle rearms the launch-on-change rule
                if (wrMode == i2cPkg::modeIdle) begin
                    lastMode <= i2cPkg::modeIdle;
                end else if (regWrData[i2cPkg::ctrlEnBit] && wrMode != lastMode &&
                             (wrMode == i2cPkg::modeWrite || wrMode == i2cPkg::modeRead) &&
                             !result.busy && !launch) begin
                    launch <= 1'b1;
                    lastMode <= wrMode;
                end
            end
            if (regWrEn && regAddr == i2cPkg::regDevAddr) begin
                devAddrReg <= regWrData;
            end
            if (regWrEn && regAddr == i2cPkg::regPtr) begin
                ptrReg <= regWrData;
            end
            if (regWrEn && regAddr == i2cPkg::regWrData) begin
                wrDataReg <= regWrData;
            end
            if (launch) begin
                ackError <= 1'b0;
            end else if (busyPrev && !result.busy) begin
                // End of transaction
                rdDataReg <= result.rdData;
                ackError <= ackError | result.ackError;
            end
        end
    end

    assign cfg = '{devAddr: devAddrReg[6:0], regPtr: ptrReg, wrData: wrDataReg,
                   launchRead: (ctrlMode == i2cPkg::modeRead)};

    always_comb begin
        regRdData = '0;
        case (regAddr)
            i2cPkg::regCtrl: begin
                regRdData[i2cPkg::ctrlEnBit] = ctrlEn;
                regRdData[i2cPkg::ctrlModeLsb +: 2] = ctrlMode;
            end
            i2cPkg::regDevAddr: regRdData = devAddrReg;
            i2cPkg::regPtr: regRdData = ptrReg;
            i2cPkg::regWrData: regRdData = wrDataReg;
            i2cPkg::regStatus: begin
                regRdData[i2cPkg::statusBusyBit] = result.busy;
                regRdData[i2cPkg::statusAckErrBit] = ackError;
            end
            i2cPkg::regRdData: regRdData = rdDataReg;
            default: regRdData = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/i2cBitEngine.sv
`timescale 1ns/10ps
`default_nettype none

module i2cBitEngine (
    input  wire logic FSM_Clk,
    input  wire logic reset,
    input  wire i2cPkg::busCmd_s cmd,
    input  wire logic cmdIssue,
    input  wire logic sdaIn,
    output logic cmdDone,
    output logic ackIn,
    output logic [i2cPkg::byteWidth-1:0] rxByte,
    output logic scl,
    output logic sdaDriveLow
);

    logic active;
    logic [i2cPkg::phaseBits-1:0] phase;
    logic [3:0] bitCnt;
    i2cPkg::busOp_e opReg;
    logic ackOutReg;
    logic [i2cPkg::byteWidth-1:0] shiftReg;

    i2cPkg::busOp_e curOp;
    logic curMsb;
    logic curAckOut;
    logic ackSlot;
    logic sclHigh;
    logic nextScl;
    logic nextSdaLow;
    logic lastStep;
    logic byteSample;

    // First step of an operation runs on the issue edge
    always_comb begin
        curOp = active ? opReg : cmd.op;
        curMsb = active ? shiftReg[i2cPkg::byteWidth-1] : cmd.data[i2cPkg::byteWidth-1];
        curAckOut = active ? ackOutReg : cmd.ackOut;
        ackSlot = (bitCnt == 4'(i2cPkg::byteWidth));
        sclHigh = (phase != '0) && (phase != i2cPkg::lastPhase);
        nextScl = scl;
        nextSdaLow = sdaDriveLow;
        lastStep = 1'b0;
        case (curOp)
            i2cPkg::opStart: begin
                nextScl = (phase == '0);
                nextSdaLow = 1'b1;
                lastStep = (phase == 1);
            end
            i2cPkg::opStop: begin
                // sda rises while scl is high
                nextScl = (phase != '0);
                nextSdaLow = (phase != i2cPkg::samplePhase);
                lastStep = (phase == i2cPkg::samplePhase);
            end
            i2cPkg::opRestart: begin
                nextScl = sclHigh;
                nextSdaLow = (phase >= i2cPkg::samplePhase);
                lastStep = (phase == i2cPkg::lastPhase);
            end
            i2cPkg::opWriteByte, i2cPkg::opReadByte: begin
                nextScl = sclHigh;
                if (phase == '0) begin
                    if (ackSlot) begin
                        nextSdaLow = (curOp == i2cPkg::opReadByte) && !curAckOut;
                    end else begin
                        nextSdaLow = (curOp == i2cPkg::opWriteByte) && !curMsb;
                    end
                end
                lastStep = ackSlot && (phase == i2cPkg::lastPhase);
            end
            default: lastStep = 1'b1;
        endcase
    end

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            active <= 1'b0;
            phase <= '0;
            bitCnt <= '0;
            cmdDone <= 1'b0;
            scl <= 1'b1;
            sdaDriveLow <= 1'b0;
        end else begin
            cmdDone <= 1'b0;
            if (active || cmdIssue) begin
                scl <= nextScl;
                sdaDriveLow <= nextSdaLow;
                if (lastStep) begin
                    active <= 1'b0;
                    phase <= '0;
                    bitCnt <= '0;
                    cmdDone <= 1'b1;
                end else begin
                    active <= 1'b1;
                    phase <= phase + 1'b1;
                    if (phase == i2cPkg::lastPhase) begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
            end
        end
    end

    assign byteSample = active && (phase == i2cPkg::samplePhase) &&
                        (opReg == i2cPkg::opWriteByte || opReg == i2cPkg::opReadByte);

    // Data bits shift in MSB first, the ninth slot is the acknowledge
    always_ff @(posedge FSM_Clk) begin
        if (cmdIssue && !active) begin
            opReg <= cmd.op;
            ackOutReg <= cmd.ackOut;
            shiftReg <= cmd.data;
        end else if (byteSample) begin
            if (ackSlot) begin
                ackIn <= sdaIn;
            end else begin
                shiftReg <= {shiftReg[i2cPkg::byteWidth-2:0], sdaIn};
            end
        end
    end

    assign rxByte = shiftReg;

    // Only one operation may be outstanding
    assert property (@(posedge FSM_Clk) disable iff (reset) cmdIssue |-> !active);

endmodule

`default_nettype wire

//--- source/i2cTransactionSeq.sv
`timescale 1ns/10ps
`default_nettype none

module i2cTransactionSeq (
    input  wire logic FSM_Clk,
    input  wire logic reset,
    input  wire i2cPkg::i2cConfig_s cfg,
    input  wire logic launch,
    input  wire logic cmdDone,
    input  wire logic ackIn,
    input  wire logic [i2cPkg::byteWidth-1:0] rxByte,
    output i2cPkg::busCmd_s cmd,
    output logic cmdIssue,
    output i2cPkg::i2cResult_s result
);

    i2cPkg::i2cConfig_s cfgReg;
    i2cPkg::addrByte_u addrByte;
    logic [2:0] opIdx;
    logic busy;
    logic credit;
    logic pending;
    logic ackError;
    logic [i2cPkg::byteWidth-1:0] rdData;

    // Write list: start, addr+W, ptr, data, stop
    // Read list: start, addr+W, ptr, restart, addr+R, read, stop
    always_comb begin
        addrByte.fields.devAddr = cfgReg.devAddr;
        addrByte.fields.rnw = cfgReg.launchRead && (opIdx == 3'd4);
        cmd.op = i2cPkg::opStop;
        cmd.data = addrByte.raw;
        // NACK ends the single read byte
        cmd.ackOut = 1'b1;
        case (opIdx)
            3'd0: cmd.op = i2cPkg::opStart;
            3'd1: cmd.op = i2cPkg::opWriteByte;
            3'd2: begin
                cmd.op = i2cPkg::opWriteByte;
                cmd.data = cfgReg.regPtr;
            end
            3'd3: begin
                if (cfgReg.launchRead) begin
                    cmd.op = i2cPkg::opRestart;
                end else begin
                    cmd.op = i2cPkg::opWriteByte;
                    cmd.data = cfgReg.wrData;
                end
            end
            3'd4: begin
                if (cfgReg.launchRead) begin
                    cmd.op = i2cPkg::opWriteByte;
                end
            end
            3'd5: begin
                if (cfgReg.launchRead) begin
                    cmd.op = i2cPkg::opReadByte;
                end
            end
            default: cmd.op = i2cPkg::opStop;
        endcase
        // Slave NACK skips the rest of the list
        if (ackError) begin
            cmd.op = i2cPkg::opStop;
        end
    end

    assign cmdIssue = pending && credit;

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            busy <= 1'b0;
            opIdx <= '0;
            credit <= 1'b1;
            pending <= 1'b0;
            ackError <= 1'b0;
            rdData <= '0;
        end else begin
            if (cmdIssue) begin
                credit <= 1'b0;
                pending <= 1'b0;
            end
            if (launch && !busy) begin
                busy <= 1'b1;
                opIdx <= '0;
                ackError <= 1'b0;
                pending <= 1'b1;
            end else if (cmdDone) begin
                credit <= 1'b1;
                if (cmd.op == i2cPkg::opStop) begin
                    busy <= 1'b0;
                end else begin
                    if (cmd.op == i2cPkg::opWriteByte && ackIn) begin
                        ackError <= 1'b1;
                    end
                    if (cmd.op == i2cPkg::opReadByte) begin
                        rdData <= rxByte;
                    end
                    opIdx <= opIdx + 1'b1;
                    pending <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge FSM_Clk) begin
        if (launch && !busy) begin
            cfgReg <= cfg;
        end
    end

    assign result = '{busy: busy, ackError: ackError, rdData: rdData};

    // Host side must wait for busy to fall
    assert property (@(posedge FSM_Clk) disable iff (reset) launch |-> !busy);
    // Credit comes back only after it was spent
    assert property (@(posedge FSM_Clk) disable iff (reset) cmdDone |-> !credit);

endmodule

`default_nettype wire

//--- source/i2cSensorBridge.sv
`timescale 1ns/10ps
`default_nettype none

module i2cSensorBridge (
    input  wire logic FSM_Clk,
    input  wire logic reset,
    input  wire logic regWrEn,
    input  wire logic [i2cPkg::regAddrWidth-1:0] regAddr,
    input  wire logic [i2cPkg::byteWidth-1:0] regWrData,
    input  wire logic sdaIn,
    output logic [i2cPkg::byteWidth-1:0] regRdData,
    output logic scl,
    output logic sdaDriveLow
);

    i2cPkg::i2cConfig_s cfg;
    i2cPkg::i2cResult_s result;
    i2cPkg::busCmd_s cmd;
    logic launch;
    logic cmdIssue;
    logic cmdDone;
    logic ackIn;
    logic [i2cPkg::byteWidth-1:0] rxByte;

    i2cRegBlock regBlock_i (
        .FSM_Clk(FSM_Clk),
        .reset(reset),
        .regWrEn(regWrEn),
        .regAddr(regAddr),
        .regWrData(regWrData),
        .result(result),
        .regRdData(regRdData),
        .cfg(cfg),
        .launch(launch)
    );

    i2cTransactionSeq seq_i (
        .FSM_Clk(FSM_Clk),
        .reset(reset),
        .cfg(cfg),
        .launch(launch),
        .cmdDone(cmdDone),
        .ackIn(ackIn),
        .rxByte(rxByte),
        .cmd(cmd),
        .cmdIssue(cmdIssue),
        .result(result)
    );

    i2cBitEngine bitEngine_i (
        .FSM_Clk(FSM_Clk),
        .reset(reset),
        .cmd(cmd),
        .cmdIssue(cmdIssue),
        .sdaIn(sdaIn),
        .cmdDone(cmdDone),
        .ackIn(ackIn),
        .rxByte(rxByte),
        .scl(scl),
        .sdaDriveLow(sdaDriveLow)
    );

endmodule

`default_nettype wire

//--- verif/i2cSlaveModel.sv
`timescale 1ns/10ps
`default_nettype none

module i2cSlaveModel (
    input  wire logic FSM_Clk,
    input  wire logic scl,
    input  wire logic sda,
    output logic sdaDriveLow,
    output int startCount,
    output int restartCount,
    output int writeCount,
    output int readCount,
    output int masterNackCount,
    output int faultCount
);

    localparam logic [6:0] devAddr = 7'h4B;

    logic [7:0] regMem [0:7];
    logic [7:0] pointer;
    logic [7:0] shiftIn;
    logic [7:0] txByte;
    logic sclPrev;
    logic sdaPrev;
    logic inFrame;
    logic restarted;
    logic addressed;
    logic rnw;
    logic reading;
    logic nackSeen;
    int bitCnt;
    int byteCnt;
    int firstBytes;
    integer seed;

    initial begin
        seed = 32'hdd3c;
        for (int i = 0; i < 8; i++) begin
            regMem[3'(i)] = 8'($random(seed));
        end
        pointer = '0;
        shiftIn = '0;
        txByte = '0;
        sclPrev = 1'b1;
        sdaPrev = 1'b1;
        inFrame = 1'b0;
        restarted = 1'b0;
        addressed = 1'b0;
        rnw = 1'b0;
        reading = 1'b0;
        nackSeen = 1'b0;
        sdaDriveLow = 1'b0;
        bitCnt = 0;
        byteCnt = 0;
        firstBytes = 0;
        startCount = 0;
        restartCount = 0;
        writeCount = 0;
        readCount = 0;
        masterNackCount = 0;
        faultCount = 0;
    end

    task reportFault(input string what);
        faultCount++;
        $display("Slave model framing fault: %s", what);
    endtask

    task startSeen();
        if (inFrame) begin
            restartCount++;
            restarted = 1'b1;
            firstBytes = byteCnt;
        end else begin
            startCount++;
            restarted = 1'b0;
            firstBytes = 0;
            nackSeen = 1'b0;
        end
        inFrame = 1'b1;
        // The scl fall that closes the start opens no bit slot
        bitCnt = -1;
        byteCnt = 0;
        reading = 1'b0;
        sdaDriveLow = 1'b0;
    endtask

    task checkFrame();
        // Frames to another address are not ours to judge
        if (addressed) begin
            if (!restarted) begin
                if (rnw || byteCnt != 3) begin
                    reportFault("write frame is not address, pointer, data, stop");
                end
            end else if (firstBytes != 2 || !rnw || byteCnt != 2 || !nackSeen) begin
                reportFault("read frame is not address, pointer, restart, address, data, NACK");
            end
        end
    endtask

    // Full byte in shiftIn, answer in the ack slot
    task takeByte();
        if (byteCnt == 0) begin
            addressed = (shiftIn[7:1] == devAddr);
            rnw = shiftIn[0];
            sdaDriveLow = addressed;
            if (addressed && rnw && !restarted) begin
                reportFault("read address without a register pointer");
            end
        end else if (addressed) begin
            sdaDriveLow = 1'b1;
            if (byteCnt == 1 && !restarted) begin
                pointer = shiftIn;
            end else if (byteCnt == 2 && !restarted) begin
                regMem[pointer[2:0]] = shiftIn;
                writeCount++;
            end else begin
                reportFault("unexpected byte from the master");
            end
        end
    endtask

    task sampleBit();
        if (bitCnt < 8) begin
            shiftIn = {shiftIn[6:0], sda};
        end else if (reading) begin
            if (sda) begin
                nackSeen = 1'b1;
                masterNackCount++;
            end else begin
                reportFault("master acknowledged the only read byte");
            end
        end
    endtask

    task endSlot();
        if (bitCnt < 7) begin
            bitCnt++;
            if (reading) begin
                txByte = txByte << 1;
                sdaDriveLow = !txByte[7];
            end
        end else if (bitCnt == 7) begin
            bitCnt = 8;
            if (reading) begin
                sdaDriveLow = 1'b0;
            end else begin
                takeByte();
            end
        end else begin
            bitCnt = 0;
            byteCnt++;
            sdaDriveLow = 1'b0;
            if (reading) begin
                reading = 1'b0;
                readCount++;
            end else if (addressed && rnw && byteCnt == 1) begin
                reading = 1'b1;
                txByte = regMem[pointer[2:0]];
                sdaDriveLow = !txByte[7];
            end
        end
    endtask

    // Bus sampled mid-cycle, edges found against the previous sample
    always @(negedge FSM_Clk) begin
        if (sclPrev && scl && sdaPrev && !sda) begin
            startSeen();
        end else if (sclPrev && scl && !sdaPrev && sda) begin
            if (inFrame) begin
                checkFrame();
            end
            inFrame = 1'b0;
            reading = 1'b0;
            sdaDriveLow = 1'b0;
        end else if (inFrame && !sclPrev && scl) begin
            sampleBit();
        end else if (inFrame && sclPrev && !scl) begin
            endSlot();
        end
        sclPrev = scl;
        sdaPrev = sda;
    end

endmodule

`default_nettype wire

//--- verif/tbI2cSensorBridge.sv
`timescale 1ns/10ps
`default_nettype none

module tbI2cSensorBridge;

    localparam int clkPeriod = 10;
    localparam int resetCycles = 8;
    localparam int txnCycles = 200;
    localparam int txnCount = 6;
    localparam int marginCycles = 400;
    localparam int idleTimeout = 2 * txnCycles;
    localparam int quietCycles = 8;
    localparam logic [6:0] sensorAddr = 7'h4B;

    logic FSM_Clk;
    logic reset;
    logic regWrEn;
    logic [i2cPkg::regAddrWidth-1:0] regAddr;
    logic [7:0] regWrData;
    logic [7:0] regRdData;
    logic scl;
    logic sdaDriveLow;
    logic slaveSdaLow;
    logic sdaLine;
    int startCount;
    int restartCount;
    int writeCount;
    int readCount;
    int masterNackCount;
    int faultCount;
    int errorCount;
    int checkCount;

    // Open-drain line shared with the slave
    assign sdaLine = !(sdaDriveLow || slaveSdaLow);

    i2cSensorBridge dut_i (
        .FSM_Clk(FSM_Clk),
        .reset(reset),
        .regWrEn(regWrEn),
        .regAddr(regAddr),
        .regWrData(regWrData),
        .sdaIn(sdaLine),
        .regRdData(regRdData),
        .scl(scl),
        .sdaDriveLow(sdaDriveLow)
    );

    i2cSlaveModel slave_i (
        .FSM_Clk(FSM_Clk),
        .scl(scl),
        .sda(sdaLine),
        .sdaDriveLow(slaveSdaLow),
        .startCount(startCount),
        .restartCount(restartCount),
        .writeCount(writeCount),
        .readCount(readCount),
        .masterNackCount(masterNackCount),
        .faultCount(faultCount)
    );

    initial begin
        FSM_Clk = 1'b0;
        forever #(clkPeriod / 2) FSM_Clk = !FSM_Clk;
    end

    initial begin
        repeat (txnCount * txnCycles + marginCycles) @(posedge FSM_Clk);
        $display("Timeout: tests still running after %0d clock cycles",
                 txnCount * txnCycles + marginCycles);
        $display("Finished with errors");
        $finish;
    end

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("Fail %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
        end
    endtask

    function automatic logic [7:0] ctrlByte(input logic en, input logic [1:0] mode);
        logic [7:0] value;
        value = '0;
        value[i2cPkg::ctrlEnBit] = en;
        value[i2cPkg::ctrlModeLsb +: 2] = mode;
        return value;
    endfunction

    task automatic regWrite(input logic [2:0] addr, input logic [7:0] data);
        @(negedge FSM_Clk);
        regWrEn = 1'b1;
        regAddr = addr;
        regWrData = data;
        @(negedge FSM_Clk);
        regWrEn = 1'b0;
    endtask

    task automatic regRead(input logic [2:0] addr, output logic [7:0] data);
        @(negedge FSM_Clk);
        regAddr = addr;
        #1;
        data = regRdData;
    endtask

    task automatic waitIdle(input string testName);
        logic [7:0] status;
        int cycles;
        cycles = 0;
        // Launch one cycle after the write, busy one cycle later
        repeat (2) @(negedge FSM_Clk);
        regRead(i2cPkg::regStatus, status);
        while (status[i2cPkg::statusBusyBit] && cycles < idleTimeout) begin
            regRead(i2cPkg::regStatus, status);
            cycles++;
        end
        if (status[i2cPkg::statusBusyBit]) begin
            errorCount++;
            $display("%s: busy did not fall within %0d cycles", testName, idleTimeout);
        end
    endtask

    task automatic afterReset();
        logic [7:0] data;
        checkValue("reset scl", 32'd1, 32'(scl));
        checkValue("reset sdaDriveLow", 32'd0, 32'(sdaDriveLow));
        regRead(i2cPkg::regStatus, data);
        checkValue("reset status", 32'd0, 32'(data));
        regRead(i2cPkg::regRdData, data);
        checkValue("reset read data", 32'd0, 32'(data));
    endtask

    task automatic sensorWrite();
        logic [7:0] status;
        int startsBefore;
        startsBefore = startCount;
        regWrite(i2cPkg::regDevAddr, {1'b0, sensorAddr});
        regWrite(i2cPkg::regPtr, 8'h03);
        regWrite(i2cPkg::regWrData, 8'hA5);
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeWrite));
        waitIdle("write");
        regRead(i2cPkg::regStatus, status);
        checkValue("write slave register", 32'hA5, 32'(slave_i.regMem[3]));
        checkValue("write ackError", 32'd0, 32'(status[i2cPkg::statusAckErrBit]));
        checkValue("write start count", startsBefore + 1, startCount);
        checkValue("write framing", 32'd0, faultCount);
    endtask

    task automatic sensorRead();
        logic [7:0] data;
        logic [7:0] status;
        int restartsBefore;
        int nacksBefore;
        int readsBefore;
        restartsBefore = restartCount;
        nacksBefore = masterNackCount;
        readsBefore = readCount;
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeIdle));
        regWrite(i2cPkg::regPtr, 8'h06);
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeRead));
        waitIdle("read");
        regRead(i2cPkg::regRdData, data);
        regRead(i2cPkg::regStatus, status);
        checkValue("read data", 32'(slave_i.regMem[6]), 32'(data));
        checkValue("read ackError", 32'd0, 32'(status[i2cPkg::statusAckErrBit]));
        checkValue("read restart count", restartsBefore + 1, restartCount);
        checkValue("read master NACK count", nacksBefore + 1, masterNackCount);
        checkValue("read slave byte count", readsBefore + 1, readCount);
        checkValue("read framing", 32'd0, faultCount);
    endtask

    task automatic wrongDeviceAddr();
        logic [7:0] status;
        int writesBefore;
        writesBefore = writeCount;
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeIdle));
        regWrite(i2cPkg::regDevAddr, {1'b0, sensorAddr ^ 7'h01});
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeWrite));
        waitIdle("wrong address");
        regRead(i2cPkg::regStatus, status);
        checkValue("wrong address ackError", 32'd1, 32'(status[i2cPkg::statusAckErrBit]));
        checkValue("wrong address scl", 32'd1, 32'(scl));
        checkValue("wrong address sdaDriveLow", 32'd0, 32'(sdaDriveLow));
        checkValue("wrong address slave writes", writesBefore, writeCount);
        // Sticky through idle, cleared by the next launch
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeIdle));
        regRead(i2cPkg::regStatus, status);
        checkValue("ackError sticky", 32'd1, 32'(status[i2cPkg::statusAckErrBit]));
        regWrite(i2cPkg::regDevAddr, {1'b0, sensorAddr});
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeWrite));
        waitIdle("relaunch");
        regRead(i2cPkg::regStatus, status);
        checkValue("relaunch status", 32'd0, 32'(status));
        checkValue("relaunch framing", 32'd0, faultCount);
    endtask

    task automatic launchOnChange();
        logic [7:0] status;
        int startsBefore;
        int writesBefore;
        startsBefore = startCount;
        writesBefore = writeCount;
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeIdle));
        regWrite(i2cPkg::regPtr, 8'h01);
        regWrite(i2cPkg::regWrData, 8'h3C);
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeWrite));
        waitIdle("first launch");
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeWrite));
        repeat (quietCycles) @(negedge FSM_Clk);
        regRead(i2cPkg::regStatus, status);
        checkValue("repeated mode busy", 32'd0, 32'(status[i2cPkg::statusBusyBit]));
        checkValue("repeated mode starts", startsBefore + 1, startCount);
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeIdle));
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b1, i2cPkg::modeWrite));
        waitIdle("second launch");
        checkValue("rearmed starts", startsBefore + 2, startCount);
        checkValue("rearmed slave writes", writesBefore + 2, writeCount);
        checkValue("rearmed slave register", 32'h3C, 32'(slave_i.regMem[1]));
    endtask

    task automatic disabledLaunch();
        logic [7:0] status;
        int startsBefore;
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b0, i2cPkg::modeIdle));
        startsBefore = startCount;
        regWrite(i2cPkg::regCtrl, ctrlByte(1'b0, i2cPkg::modeWrite));
        repeat (quietCycles) @(negedge FSM_Clk);
        regRead(i2cPkg::regStatus, status);
        checkValue("disabled busy", 32'd0, 32'(status[i2cPkg::statusBusyBit]));
        checkValue("disabled starts", startsBefore, startCount);
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        reset = 1'b1;
        regWrEn = 1'b0;
        regAddr = '0;
        regWrData = '0;
        repeat (resetCycles) @(negedge FSM_Clk);
        reset = 1'b0;
        afterReset();
        sensorWrite();
        sensorRead();
        wrongDeviceAddr();
        launchOnChange();
        disabledLaunch();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- i2cSensorBridge.f
source/i2cPkg.sv
source/i2cRegBlock.sv
source/i2cBitEngine.sv
source/i2cTransactionSeq.sv
source/i2cSensorBridge.sv
verif/i2cSlaveModel.sv
verif/tbI2cSensorBridge.sv

//--- Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      ?= tbI2cSensorBridge
FILELIST ?= i2cSensorBridge.f
BUILDDIR ?= obj_dir
LOG      ?= sim.log
PASSMSG  ?= Finished with no errors

SOURCES  := $(shell cat $(FILELIST))
SIMBIN   := $(BUILDDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) | tee $(LOG)
	@grep -qx "$(PASSMSG)" $(LOG) && echo "Simulation passed" || \
		{ echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILDDIR) $(LOG)
